/* Bender.yml */
package:
  name: core_regs

export_include_dirs:
  - .

sources:
  - core_pkg.sv
  - regport_decoder.sv
  - global_regs.sv
  - route_table.sv
  - regport_resp_mux.sv
  - core_regs_top.sv
  - target: test
    files:
      - tb_core_regs.sv

/* core_macros.svh */
/*
  Core register map constants
  Word addresses, reset values and build identity of the bus-clock core
*/
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Global register words
`define CORE_REG_GIT_HASH    14'h000
`define CORE_REG_NUM_CE      14'h004
`define CORE_REG_LOCAL_ADDR  14'h008
`define CORE_REG_SCRATCH     14'h00C

// Route table window, one word per entry
`define CORE_REG_BASE_ROUTE  14'h010
`define CORE_ROUTE_ENTRIES   16

// Build identity
`define CORE_GIT_HASH        32'h5A3C_91E7
`define CORE_NUM_CE          32'd4

// Power-up scratch, selects SPI mux 2 with CPLD out of reset
`define CORE_SCRATCH_RESET   32'h0000_0002
`define CORE_UPLINK_PORT     4'd0

`endif

/* core_pkg.sv */
/*
  Core types
  Register port, stream destination and crossbar port types
*/
`include "core_macros.svh"

package core_pkg;

  //////////////////////////////
  // Register port
  //////////////////////////////

  // Byte address, word aligned in practice
  typedef logic [13:0] reg_addr_t;
  typedef logic [31:0] reg_data_t;

  //////////////////////////////
  // Stream routing
  //////////////////////////////

  // Crossbar output port number
  typedef logic [3:0] port_t;

  // Destination address
  // Upper byte is the device, low bits the endpoint
  typedef logic [15:0] sid_dst_t;

  // Index into the route table
  typedef logic [$clog2(`CORE_ROUTE_ENTRIES)-1:0] route_idx_t;

endpackage

/* core_regs_top.sv */
/*
  Core register top
  Decoder, global bank, route table and response merge on bus_clk
*/
`timescale 1ns/1ps

module core_regs_top (
  input  logic                i_bus_clk,
  input  logic                i_bus_rst,
  input  logic                i_reg_wr_req,
  input  core_pkg::reg_addr_t i_reg_wr_addr,
  input  core_pkg::reg_data_t i_reg_wr_data,
  input  logic                i_reg_rd_req,
  input  core_pkg::reg_addr_t i_reg_rd_addr,
  output logic                o_reg_rd_resp,
  output core_pkg::reg_data_t o_reg_rd_data,
  output logic                o_reg_rd_err,
  input  logic                i_dst_stb,
  input  core_pkg::sid_dst_t  i_dst,
  output logic                o_port_stb,
  output core_pkg::port_t     o_port,
  output logic [2:0]          o_spi_mux,
  output logic                o_cpld_reset
);
  import core_pkg::*;

  //////////////////////////////
  // Decoded register traffic
  //////////////////////////////

  logic      glob_wr_stb;
  logic      route_wr_stb;
  reg_addr_t wr_addr;
  reg_data_t wr_data;
  logic      glob_rd_stb;
  logic      route_rd_stb;
  logic      rd_miss_stb;
  reg_addr_t rd_addr;

  // Region replies
  logic      glob_rd_resp;
  reg_data_t glob_rd_data;
  logic      route_rd_resp;
  reg_data_t route_rd_data;

  // Device address for the lookup
  logic [7:0] local_addr;

  regport_decoder u_decoder (
    .i_clk          (i_bus_clk),
    .i_rst          (i_bus_rst),
    .i_reg_wr_req   (i_reg_wr_req),
    .i_reg_wr_addr  (i_reg_wr_addr),
    .i_reg_wr_data  (i_reg_wr_data),
    .i_reg_rd_req   (i_reg_rd_req),
    .i_reg_rd_addr  (i_reg_rd_addr),
    .o_glob_wr_stb  (glob_wr_stb),
    .o_route_wr_stb (route_wr_stb),
    .o_wr_addr      (wr_addr),
    .o_wr_data      (wr_data),
    .o_glob_rd_stb  (glob_rd_stb),
    .o_route_rd_stb (route_rd_stb),
    .o_rd_miss_stb  (rd_miss_stb),
    .o_rd_addr      (rd_addr)
  );

  global_regs u_global_regs (
    .i_clk (i_bus_clk), .i_rst (i_bus_rst),
    .i_wr_stb (glob_wr_stb), .i_wr_addr (wr_addr), .i_wr_data (wr_data),
    .i_rd_stb (glob_rd_stb), .i_rd_addr (rd_addr),
    .o_rd_resp (glob_rd_resp), .o_rd_data (glob_rd_data),
    .o_local_addr (local_addr), .o_spi_mux (o_spi_mux), .o_cpld_reset (o_cpld_reset)
  );

  route_table u_route_table (
    .i_clk (i_bus_clk), .i_rst (i_bus_rst),
    .i_wr_stb (route_wr_stb), .i_wr_addr (wr_addr), .i_wr_data (wr_data),
    .i_rd_stb (route_rd_stb), .i_rd_addr (rd_addr), .i_local_addr (local_addr),
    .i_dst_stb (i_dst_stb), .i_dst (i_dst),
    .o_rd_resp (route_rd_resp), .o_rd_data (route_rd_data),
    .o_port_stb (o_port_stb), .o_port (o_port)
  );

  regport_resp_mux u_resp_mux (
    .i_clk (i_bus_clk), .i_rst (i_bus_rst),
    .i_glob_rd_resp (glob_rd_resp), .i_glob_rd_data (glob_rd_data),
    .i_route_rd_resp (route_rd_resp), .i_route_rd_data (route_rd_data),
    .i_rd_miss_stb (rd_miss_stb),
    .o_reg_rd_resp (o_reg_rd_resp), .o_reg_rd_data (o_reg_rd_data),
    .o_reg_rd_err (o_reg_rd_err)
  );

endmodule

/* core_regs_trace.txt */
# op T name | W addr data | R addr data err | Q addr data err addr data err
# op L dst port | P spi_mux cpld_reset | all numbers hex
T reset_values
P 2 0
R 000c 00000002 0
R 0000 5a3c91e7 0
R 0004 00000004 0
R 0008 00000000 0
L 0005 0
T scratch
W 000c 0000000d
R 000c 0000000d 0
P 5 1
W 000c a5a5fff3
Q 000c a5a5fff3 0 0004 00000004 0
P 3 0
T masking
W 0008 12345603
R 0008 00000003 0
W 0014 fffffff7
R 0014 00000007 0
W 004c 0000002b
R 004c 0000000b 0
R 0010 00000000 0
T lookup
L 0301 7
L 030f b
L 0300 0
L 0401 0
L ff0f 0
T unmapped
R 0050 00000000 1
R 0002 00000000 1
W 0050 00000009
W 0011 00000009
W 000e 00000001
Q 0011 00000000 1 0010 00000000 0
R 0008 00000003 0
R 000c a5a5fff3 0
P 3 0

/* files.f */
+incdir+.
core_pkg.sv
regport_decoder.sv
global_regs.sv
route_table.sv
regport_resp_mux.sv
core_regs_top.sv
tb_core_regs.sv

/* global_regs.sv */
/*
  Global register bank
  Scratch, local address, engine count and build hash.
  Scratch also drives the SPI mux select and CPLD reset
*/
`timescale 1ns/1ps
`include "core_macros.svh"

module global_regs (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_wr_stb,
  input  core_pkg::reg_addr_t i_wr_addr,
  input  core_pkg::reg_data_t i_wr_data,
  input  logic                i_rd_stb,
  input  core_pkg::reg_addr_t i_rd_addr,
  output logic                o_rd_resp,
  output core_pkg::reg_data_t o_rd_data,
  output logic [7:0]          o_local_addr,
  output logic [2:0]          o_spi_mux,
  output logic                o_cpld_reset
);
  import core_pkg::*;

  reg_data_t  scratch_q;
  logic [7:0] local_addr_q;

  //////////////////////////////
  // Write side
  //////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      scratch_q    <= `CORE_SCRATCH_RESET;
      local_addr_q <= 8'h00;
    end else if (i_wr_stb) begin
      case (i_wr_addr)
        `CORE_REG_SCRATCH:    scratch_q    <= i_wr_data;
        // Device address, one byte wide
        `CORE_REG_LOCAL_ADDR: local_addr_q <= i_wr_data[7:0];
        // Hash and engine count are read only
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // Read side
  //////////////////////////////

  // Response one cycle after the strobe
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rd_resp <= 1'b0;
    end else begin
      o_rd_resp <= i_rd_stb;
    end
  end

  always_ff @(posedge i_clk) begin
    case (i_rd_addr)
      `CORE_REG_GIT_HASH:   o_rd_data <= `CORE_GIT_HASH;
      `CORE_REG_NUM_CE:     o_rd_data <= `CORE_NUM_CE;
      `CORE_REG_LOCAL_ADDR: o_rd_data <= {24'h000000, local_addr_q};
      `CORE_REG_SCRATCH:    o_rd_data <= scratch_q;
      default:              o_rd_data <= '0;
    endcase
  end

  // Board control straight from scratch
  assign o_local_addr = local_addr_q;
  assign o_spi_mux    = scratch_q[2:0];
  assign o_cpld_reset = scratch_q[3];

endmodule

/* regport_decoder.sv */
/*
  Register port decoder
  Registers the write and read strobes and steers each one to the
  global bank, the route table, or the miss path
*/
`timescale 1ns/1ps
`include "core_macros.svh"

module regport_decoder (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_reg_wr_req,
  input  core_pkg::reg_addr_t i_reg_wr_addr,
  input  core_pkg::reg_data_t i_reg_wr_data,
  input  logic               i_reg_rd_req,
  input  core_pkg::reg_addr_t i_reg_rd_addr,
  output logic               o_glob_wr_stb,
  output logic               o_route_wr_stb,
  output core_pkg::reg_addr_t o_wr_addr,
  output core_pkg::reg_data_t o_wr_data,
  output logic               o_glob_rd_stb,
  output logic               o_route_rd_stb,
  output logic               o_rd_miss_stb,
  output core_pkg::reg_addr_t o_rd_addr
);
  import core_pkg::*;

  // First byte past the route window
  localparam reg_addr_t ROUTE_END =
    reg_addr_t'(`CORE_REG_BASE_ROUTE + 4 * `CORE_ROUTE_ENTRIES);

  // One of the four global words
  function automatic logic is_glob(input reg_addr_t addr);
    return (addr == `CORE_REG_GIT_HASH) || (addr == `CORE_REG_NUM_CE) ||
           (addr == `CORE_REG_LOCAL_ADDR) || (addr == `CORE_REG_SCRATCH);
  endfunction

  // Aligned word inside the route window
  function automatic logic is_route(input reg_addr_t addr);
    return (addr >= `CORE_REG_BASE_ROUTE) && (addr < ROUTE_END) &&
           (addr[1:0] == 2'b00);
  endfunction

  // Strobes, cleared on reset
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_glob_wr_stb  <= 1'b0;
      o_route_wr_stb <= 1'b0;
      o_glob_rd_stb  <= 1'b0;
      o_route_rd_stb <= 1'b0;
      o_rd_miss_stb  <= 1'b0;
    end else begin
      // Unmapped writes simply vanish here
      o_glob_wr_stb  <= i_reg_wr_req && is_glob(i_reg_wr_addr);
      o_route_wr_stb <= i_reg_wr_req && is_route(i_reg_wr_addr);
      o_glob_rd_stb  <= i_reg_rd_req && is_glob(i_reg_rd_addr);
      o_route_rd_stb <= i_reg_rd_req && is_route(i_reg_rd_addr);
      // Exactly one read outcome per request
      o_rd_miss_stb  <= i_reg_rd_req && !is_glob(i_reg_rd_addr) &&
                        !is_route(i_reg_rd_addr);
    end
  end

  // Address and data follow the strobes
  always_ff @(posedge i_clk) begin
    o_wr_addr <= i_reg_wr_addr;
    o_wr_data <= i_reg_wr_data;
    o_rd_addr <= i_reg_rd_addr;
  end

endmodule

/* regport_resp_mux.sv */
/*
  Read response merge
  Folds region responses and delayed misses into one registered reply
*/
`timescale 1ns/1ps

module regport_resp_mux (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_glob_rd_resp,
  input  core_pkg::reg_data_t i_glob_rd_data,
  input  logic                i_route_rd_resp,
  input  core_pkg::reg_data_t i_route_rd_data,
  input  logic                i_rd_miss_stb,
  output logic                o_reg_rd_resp,
  output core_pkg::reg_data_t o_reg_rd_data,
  output logic                o_reg_rd_err
);
  import core_pkg::*;

  logic      miss_q;
  reg_data_t resp_data;

  // Miss waits one cycle, in step with the regions
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      miss_q <= 1'b0;
    end else begin
      miss_q <= i_rd_miss_stb;
    end
  end

  // At most one source active per cycle, a miss gives zero
  assign resp_data = i_glob_rd_resp  ? i_glob_rd_data  :
                     i_route_rd_resp ? i_route_rd_data : '0;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_reg_rd_resp <= 1'b0;
      o_reg_rd_err  <= 1'b0;
    end else begin
      o_reg_rd_resp <= i_glob_rd_resp | i_route_rd_resp | miss_q;
      o_reg_rd_err  <= miss_q;
    end
  end

  always_ff @(posedge i_clk) begin
    o_reg_rd_data <= resp_data;
  end

endmodule

/* route_table.sv */
/*
  Stream route table
  Register-programmed map from destination endpoint to crossbar port,
  with a one-cycle lookup for the stream side
*/
`timescale 1ns/1ps
`include "core_macros.svh"

module route_table (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_wr_stb,
  input  core_pkg::reg_addr_t i_wr_addr,
  input  core_pkg::reg_data_t i_wr_data,
  input  logic                i_rd_stb,
  input  core_pkg::reg_addr_t i_rd_addr,
  input  logic [7:0]          i_local_addr,
  input  logic                i_dst_stb,
  input  core_pkg::sid_dst_t  i_dst,
  output logic                o_rd_resp,
  output core_pkg::reg_data_t o_rd_data,
  output logic                o_port_stb,
  output core_pkg::port_t     o_port
);
  import core_pkg::*;

  localparam int IDX_W = $bits(route_idx_t);

  port_t      route_mem [`CORE_ROUTE_ENTRIES];
  reg_addr_t  wr_off;
  reg_addr_t  rd_off;
  route_idx_t wr_idx;
  route_idx_t rd_idx;
  route_idx_t dst_idx;

  // Word offsets into the table window
  assign wr_off  = i_wr_addr - `CORE_REG_BASE_ROUTE;
  assign rd_off  = i_rd_addr - `CORE_REG_BASE_ROUTE;
  assign wr_idx  = wr_off[IDX_W+1:2];
  assign rd_idx  = rd_off[IDX_W+1:2];
  // Endpoint bits of the destination
  assign dst_idx = i_dst[IDX_W-1:0];

  //////////////////////////////
  // Table storage
  //////////////////////////////

  // All entries point at the uplink after reset
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < `CORE_ROUTE_ENTRIES; i++) begin
        route_mem[i] <= '0;
      end
    end else if (i_wr_stb) begin
      route_mem[wr_idx] <= i_wr_data[$bits(port_t)-1:0];
    end
  end

  // Register readback, zero-extended
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rd_resp <= 1'b0;
    end else begin
      o_rd_resp <= i_rd_stb;
    end
  end

  always_ff @(posedge i_clk) begin
    o_rd_data <= reg_data_t'(route_mem[rd_idx]);
  end

  //////////////////////////////
  // Lookup
  //////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_port_stb <= 1'b0;
    end else begin
      o_port_stb <= i_dst_stb;
    end
  end

  // Foreign device goes out the uplink
  always_ff @(posedge i_clk) begin
    if (i_dst[15:8] == i_local_addr) begin
      o_port <= route_mem[dst_idx];
    end else begin
      o_port <= `CORE_UPLINK_PORT;
    end
  end

endmodule

/* tb_core_regs.sv */
/*
  Testbench for core_regs_top
  Replays the register and lookup trace and checks every response
*/
`timescale 1ns/1ps

module tb_core_regs;
  import core_pkg::*;

  localparam string TRACE_FILE = "core_regs_trace.txt";

  logic       bus_clk;
  logic       bus_rst;
  logic       i_reg_wr_req;
  reg_addr_t  i_reg_wr_addr;
  reg_data_t  i_reg_wr_data;
  logic       i_reg_rd_req;
  reg_addr_t  i_reg_rd_addr;
  logic       o_reg_rd_resp;
  reg_data_t  o_reg_rd_data;
  logic       o_reg_rd_err;
  logic       i_dst_stb;
  sid_dst_t   i_dst;
  logic       o_port_stb;
  port_t      o_port;
  logic [2:0] o_spi_mux;
  logic       o_cpld_reset;

  // Run bookkeeping
  int    error_count = 0;
  int    check_count = 0;
  int    test_count = 0;
  int    test_errors = 0;
  int    cycle_count = 0;
  int    cycle_limit = 0;
  int    trace_lines;
  string test_name = "";

  core_regs_top dut (
    .i_bus_clk     (bus_clk),
    .i_bus_rst     (bus_rst),
    .i_reg_wr_req  (i_reg_wr_req),
    .i_reg_wr_addr (i_reg_wr_addr),
    .i_reg_wr_data (i_reg_wr_data),
    .i_reg_rd_req  (i_reg_rd_req),
    .i_reg_rd_addr (i_reg_rd_addr),
    .o_reg_rd_resp (o_reg_rd_resp),
    .o_reg_rd_data (o_reg_rd_data),
    .o_reg_rd_err  (o_reg_rd_err),
    .i_dst_stb     (i_dst_stb),
    .i_dst         (i_dst),
    .o_port_stb    (o_port_stb),
    .o_port        (o_port),
    .o_spi_mux     (o_spi_mux),
    .o_cpld_reset  (o_cpld_reset)
  );

  //////////////////////////////
  // Clock and watchdog
  //////////////////////////////

  // 8 ns period
  initial begin
    bus_clk = 1'b0;
    forever #4 bus_clk = ~bus_clk;
  end

  // Limit known once the trace is counted
  initial begin
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge bus_clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", cycle_limit);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////
  // Checks and operations
  //////////////////////////////

  task automatic check_value(input string sig, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t ns: %s got 0x%08h expected 0x%08h",
               $time, sig, got, exp);
      error_count++;
      test_errors++;
    end
  endtask

  // One line per finished test
  task automatic finish_test();
    if (test_name != "") begin
      $display("Test %-14s %s (%0d errors)", test_name,
               (test_errors == 0) ? "ok" : "FAILED", test_errors);
    end
  endtask

  // All operations start and end on a falling edge
  task automatic do_write(input reg_addr_t addr, input reg_data_t data);
    i_reg_wr_req  = 1'b1;
    i_reg_wr_addr = addr;
    i_reg_wr_data = data;
    @(negedge bus_clk);
    i_reg_wr_req  = 1'b0;
  endtask

  // Response lands 3 cycles after the request
  task automatic do_read(input reg_addr_t addr, input reg_data_t exp_data,
                         input logic exp_err);
    i_reg_rd_req  = 1'b1;
    i_reg_rd_addr = addr;
    @(negedge bus_clk);
    i_reg_rd_req  = 1'b0;
    repeat (2) @(negedge bus_clk);
    check_value("o_reg_rd_resp", o_reg_rd_resp, 1);
    check_value("o_reg_rd_data", o_reg_rd_data, exp_data);
    check_value("o_reg_rd_err", o_reg_rd_err, exp_err);
  endtask

  // Two back-to-back reads answered in order
  task automatic do_read_pair(input reg_addr_t a1, input reg_data_t d1, input logic e1,
                              input reg_addr_t a2, input reg_data_t d2, input logic e2);
    i_reg_rd_req  = 1'b1;
    i_reg_rd_addr = a1;
    @(negedge bus_clk);
    i_reg_rd_addr = a2;
    @(negedge bus_clk);
    i_reg_rd_req  = 1'b0;
    @(negedge bus_clk);
    check_value("o_reg_rd_resp", o_reg_rd_resp, 1);
    check_value("o_reg_rd_data", o_reg_rd_data, d1);
    check_value("o_reg_rd_err", o_reg_rd_err, e1);
    @(negedge bus_clk);
    check_value("o_reg_rd_resp", o_reg_rd_resp, 1);
    check_value("o_reg_rd_data", o_reg_rd_data, d2);
    check_value("o_reg_rd_err", o_reg_rd_err, e2);
  endtask

  // Port result one cycle after the strobe
  task automatic do_lookup(input sid_dst_t dst, input port_t exp_port);
    i_dst_stb = 1'b1;
    i_dst     = dst;
    @(negedge bus_clk);
    i_dst_stb = 1'b0;
    check_value("o_port_stb", o_port_stb, 1);
    check_value("o_port", o_port, exp_port);
  endtask

  // Board pins, with every response strobe idle
  task automatic check_pins(input logic [2:0] exp_mux, input logic exp_rst);
    @(negedge bus_clk);
    check_value("o_spi_mux", o_spi_mux, exp_mux);
    check_value("o_cpld_reset", o_cpld_reset, exp_rst);
    check_value("o_reg_rd_resp", o_reg_rd_resp, 0);
    check_value("o_reg_rd_err", o_reg_rd_err, 0);
    check_value("o_port_stb", o_port_stb, 0);
  endtask

  //////////////////////////////
  // Trace replay
  //////////////////////////////

  task automatic count_trace_lines(output int lines);
    int    fd;
    string line;
    fd = $fopen(TRACE_FILE, "r");
    lines = -1;
    if (fd != 0) begin
      lines = 0;
      while ($fgets(line, fd)) begin
        lines++;
      end
      $fclose(fd);
    end
  endtask

  task automatic run_trace();
    int          fd;
    int          n;
    string       line;
    string       op;
    string       name;
    logic [31:0] f[6];
    fd = $fopen(TRACE_FILE, "r");
    while ($fgets(line, fd)) begin
      n = $sscanf(line, "%s", op);
      // Blank lines and comments
      if (n < 1 || op[0] == "#") begin
        continue;
      end
      case (op)
        "T": begin
          void'($sscanf(line, "%s %s", op, name));
          finish_test();
          test_name   = name;
          test_errors = 0;
          test_count++;
        end
        "W": begin
          void'($sscanf(line, "%s %h %h", op, f[0], f[1]));
          do_write(reg_addr_t'(f[0]), f[1]);
        end
        "R": begin
          void'($sscanf(line, "%s %h %h %h", op, f[0], f[1], f[2]));
          do_read(reg_addr_t'(f[0]), f[1], f[2][0]);
        end
        "Q": begin
          void'($sscanf(line, "%s %h %h %h %h %h %h", op,
                        f[0], f[1], f[2], f[3], f[4], f[5]));
          do_read_pair(reg_addr_t'(f[0]), f[1], f[2][0],
                       reg_addr_t'(f[3]), f[4], f[5][0]);
        end
        "L": begin
          void'($sscanf(line, "%s %h %h", op, f[0], f[1]));
          do_lookup(sid_dst_t'(f[0]), port_t'(f[1]));
        end
        "P": begin
          void'($sscanf(line, "%s %h %h", op, f[0], f[1]));
          check_pins(f[0][2:0], f[1][0]);
        end
        default: begin
          $display("Error at %0t ns: unknown trace opcode %s", $time, op);
          error_count++;
          test_errors++;
        end
      endcase
    end
    $fclose(fd);
    finish_test();
  endtask

  initial begin
    bus_rst       = 1'b1;
    i_reg_wr_req  = 1'b0;
    i_reg_wr_addr = '0;
    i_reg_wr_data = '0;
    i_reg_rd_req  = 1'b0;
    i_reg_rd_addr = '0;
    i_dst_stb     = 1'b0;
    i_dst         = '0;
    count_trace_lines(trace_lines);
    if (trace_lines < 0) begin
      $display("Could not open trace file %s", TRACE_FILE);
      $display("Simulation failed");
      $finish;
    end else begin
      cycle_limit = trace_lines * 8 + 100;
      // Reset over 3 rising edges
      repeat (3) @(negedge bus_clk);
      bus_rst = 1'b0;
      run_trace();
      $display("Totals: %0d tests, %0d checks, %0d errors",
               test_count, check_count, error_count);
      if (error_count == 0) begin
        $display("Simulation passed");
      end else begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule
